// File: hdl/sasanqua_pkg.sv
`default_nettype none

package sasanqua_pkg;

    typedef enum logic [1:0] {
        KIND_INST_READ  = 2'd0,
        KIND_DATA_READ  = 2'd1,
        KIND_DATA_WRITE = 2'd2
    } access_kind_t;

    typedef struct packed {
        access_kind_t kind;
        logic [31:0]  addr;
        logic [31:0]  wdata;
        logic [3:0]   wstrb;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } mem_rsp_t;

    // Single-beat AXI payloads
    typedef struct packed {
        logic [31:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    typedef struct packed {
        access_kind_t kind;
        logic         err;
        logic [31:0]  addr;
    } access_event_t;

    typedef logic [11:0] csr_addr_t;

    localparam csr_addr_t CSR_READ_COUNT  = 12'h000;
    localparam csr_addr_t CSR_WRITE_COUNT = 12'h001;
    localparam csr_addr_t CSR_ERROR_COUNT = 12'h002;
    localparam csr_addr_t CSR_ERROR_ADDR  = 12'h003;

endpackage

`default_nettype wire

// File: hdl/access_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module access_arbiter (
    input  wire                    clk,
    input  wire                    rst,

    input  sasanqua_pkg::mem_req_t inst_req,
    input  wire                    inst_valid,
    output logic                   inst_ready,

    input  sasanqua_pkg::mem_req_t data_req,
    input  wire                    data_valid,
    output logic                   data_ready,

    output sasanqua_pkg::mem_req_t sel_req,
    output logic                   sel_valid,
    input  wire                    sel_ready,
    output logic                   sel_is_data
);

    import sasanqua_pkg::*;

    // Data side has fixed priority over fetch
    always_comb begin
        if (data_valid) begin
            sel_req = data_req;
        end else begin
            sel_req      = inst_req;
            sel_req.kind = KIND_INST_READ;
        end
    end

    assign sel_valid = data_valid | inst_valid;

    // Ready only reaches the winning port
    assign data_ready = sel_ready & data_valid;
    assign inst_ready = sel_ready & ~data_valid;

    // Remember the winner for response routing
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_is_data <= 1'b0;
        end else if (sel_valid && sel_ready) begin
            sel_is_data <= data_valid;
        end
    end

endmodule

`default_nettype wire

// File: hdl/axi_access_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module axi_access_fsm (
    input  wire                         clk,
    input  wire                         rst,

    input  sasanqua_pkg::mem_req_t      sel_req,
    input  wire                         sel_valid,
    output logic                        sel_ready,
    input  wire                         sel_is_data,

    output sasanqua_pkg::axi_ar_t       ar,
    output logic                        ar_valid,
    input  wire                         ar_ready,
    output sasanqua_pkg::axi_aw_t       aw,
    output logic                        aw_valid,
    input  wire                         aw_ready,
    output sasanqua_pkg::axi_w_t        w,
    output logic                        w_valid,
    input  wire                         w_ready,
    input  sasanqua_pkg::axi_r_t        r,
    input  wire                         r_valid,
    output logic                        r_ready,
    input  sasanqua_pkg::axi_b_t        b,
    input  wire                         b_valid,
    output logic                        b_ready,

    output logic                        wd_start,
    output logic                        wd_stop,
    input  wire                         wd_expired,

    output sasanqua_pkg::mem_rsp_t      inst_rsp,
    output logic                        inst_rsp_valid,
    output sasanqua_pkg::mem_rsp_t      data_rsp,
    output logic                        data_rsp_valid,

    output logic                        event_valid,
    output sasanqua_pkg::access_event_t event_info
);

    import sasanqua_pkg::*;

    typedef enum logic [1:0] {IDLE, ADDR, RESP, DONE} state_t;

    state_t   state;
    state_t   state_n;
    mem_req_t req_q;
    mem_rsp_t rsp_q;
    logic     take;
    logic     is_write;
    logic     addr_pend;
    logic     r_take;
    logic     b_take;

    assign take     = sel_valid && sel_ready;
    assign is_write = req_q.kind == KIND_DATA_WRITE;
    assign r_take   = r_valid && r_ready;
    assign b_take   = b_valid && b_ready;

    // Any address or data beat still waiting past this edge
    assign addr_pend = (ar_valid && !ar_ready) || (aw_valid && !aw_ready) ||
                       (w_valid && !w_ready);

    always_comb begin
        state_n = state;
        case (state)
            IDLE: if (take) state_n = ADDR;
            ADDR: if (wd_expired || !addr_pend) state_n = wd_expired ? DONE : RESP;
            RESP: if (r_take || b_take || wd_expired) state_n = DONE;
            DONE: state_n = IDLE;
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            sel_ready <= 1'b0;
            ar_valid  <= 1'b0;
            aw_valid  <= 1'b0;
            w_valid   <= 1'b0;
        end else begin
            state     <= state_n;
            sel_ready <= state_n == IDLE;
            if (state == IDLE && take) begin
                ar_valid <= sel_req.kind != KIND_DATA_WRITE;
                aw_valid <= sel_req.kind == KIND_DATA_WRITE;
                w_valid  <= sel_req.kind == KIND_DATA_WRITE;
            end else if (state == ADDR && wd_expired) begin
                // Abandon the address phase on timeout
                ar_valid <= 1'b0;
                aw_valid <= 1'b0;
                w_valid  <= 1'b0;
            end else if (state == ADDR) begin
                if (ar_ready) ar_valid <= 1'b0;
                if (aw_ready) aw_valid <= 1'b0;
                if (w_ready) w_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_q <= sel_req;
        end
        if (state == RESP && r_take) begin
            rsp_q <= '{rdata: r.data, err: (r.resp != RESP_OKAY)};
        end else if (state == RESP && b_take) begin
            rsp_q <= '{rdata: 32'd0, err: (b.resp != RESP_OKAY)};
        end else if ((state == ADDR || state == RESP) && wd_expired) begin
            rsp_q <= '{rdata: 32'd0, err: 1'b1};
        end
    end

    assign ar = '{addr: req_q.addr};
    assign aw = '{addr: req_q.addr};
    assign w  = '{data: req_q.wdata, strb: req_q.wstrb};

    assign r_ready = state == RESP && !is_write;
    assign b_ready = state == RESP && is_write;

    assign wd_start = take;
    assign wd_stop  = state == DONE;

    assign inst_rsp       = rsp_q;
    assign data_rsp       = rsp_q;
    assign inst_rsp_valid = state == DONE && !sel_is_data;
    assign data_rsp_valid = state == DONE && sel_is_data;

    assign event_valid = state == DONE;
    assign event_info  = '{kind: req_q.kind, err: rsp_q.err, addr: req_q.addr};

endmodule

`default_nettype wire

// File: hdl/bus_watchdog.sv
`timescale 1ns/100ps
`default_nettype none

module bus_watchdog #(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  wd_start,
    input  wire  wd_stop,
    output logic wd_expired
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic             running;
    logic [CNT_W-1:0] count;

    assign wd_expired = running && (count == CNT_W'(TIMEOUT_CYCLES));

    always_ff @(posedge clk) begin
        if (rst || wd_stop) begin
            running <= 1'b0;
            count   <= '0;
        end else if (wd_start) begin
            running <= 1'b1;
            count   <= '0;
        end else if (running) begin
            // One expiry pulse, then wait for stop
            if (wd_expired) running <= 1'b0;
            else if (count != CNT_W'(TIMEOUT_CYCLES)) count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/csr_bank.sv
`timescale 1ns/100ps
`default_nettype none

module csr_bank (
    input  wire                         clk,
    input  wire                         rst,

    input  wire                         event_valid,
    input  sasanqua_pkg::access_event_t event_info,

    input  wire                         csr_rden,
    input  sasanqua_pkg::csr_addr_t     csr_raddr,
    output logic                        csr_rvalid,
    output logic [31:0]                 csr_rdata,
    input  wire                         csr_wren,
    input  sasanqua_pkg::csr_addr_t     csr_waddr,
    input  wire  [31:0]                 csr_wdata
);

    import sasanqua_pkg::*;

    logic [31:0] read_count;
    logic [31:0] write_count;
    logic [31:0] error_count;
    logic [31:0] error_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            read_count  <= 32'd0;
            write_count <= 32'd0;
            error_count <= 32'd0;
            error_addr  <= 32'd0;
        end else begin
            if (event_valid) begin
                if (event_info.err) begin
                    error_count <= error_count + 32'd1;
                    error_addr  <= event_info.addr;
                end else if (event_info.kind == KIND_DATA_WRITE) begin
                    write_count <= write_count + 32'd1;
                end else begin
                    read_count <= read_count + 32'd1;
                end
            end
            // Software write lands last and wins
            if (csr_wren) begin
                case (csr_waddr)
                    CSR_READ_COUNT:  read_count  <= csr_wdata;
                    CSR_WRITE_COUNT: write_count <= csr_wdata;
                    CSR_ERROR_COUNT: error_count <= csr_wdata;
                    CSR_ERROR_ADDR:  error_addr  <= csr_wdata;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_rvalid <= 1'b0;
        end else begin
            csr_rvalid <= csr_rden;
        end
    end

    always_ff @(posedge clk) begin
        if (csr_rden) begin
            case (csr_raddr)
                CSR_READ_COUNT:  csr_rdata <= read_count;
                CSR_WRITE_COUNT: csr_rdata <= write_count;
                CSR_ERROR_COUNT: csr_rdata <= error_count;
                CSR_ERROR_ADDR:  csr_rdata <= error_addr;
                default:         csr_rdata <= 32'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/sasanqua.sv
`timescale 1ns/100ps
`default_nettype none

module sasanqua #(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  wire                     clk,
    input  wire                     rst,

    // Request and response ports
    input  sasanqua_pkg::mem_req_t  inst_req,
    input  wire                     inst_valid,
    output logic                    inst_ready,
    output sasanqua_pkg::mem_rsp_t  inst_rsp,
    output logic                    inst_rsp_valid,
    input  sasanqua_pkg::mem_req_t  data_req,
    input  wire                     data_valid,
    output logic                    data_ready,
    output sasanqua_pkg::mem_rsp_t  data_rsp,
    output logic                    data_rsp_valid,

    // AXI master
    output sasanqua_pkg::axi_ar_t   ar,
    output logic                    ar_valid,
    input  wire                     ar_ready,
    output sasanqua_pkg::axi_aw_t   aw,
    output logic                    aw_valid,
    input  wire                     aw_ready,
    output sasanqua_pkg::axi_w_t    w,
    output logic                    w_valid,
    input  wire                     w_ready,
    input  sasanqua_pkg::axi_r_t    r,
    input  wire                     r_valid,
    output logic                    r_ready,
    input  sasanqua_pkg::axi_b_t    b,
    input  wire                     b_valid,
    output logic                    b_ready,

    // CSR access
    input  wire                     csr_rden,
    input  sasanqua_pkg::csr_addr_t csr_raddr,
    output logic                    csr_rvalid,
    output logic [31:0]             csr_rdata,
    input  wire                     csr_wren,
    input  sasanqua_pkg::csr_addr_t csr_waddr,
    input  wire  [31:0]             csr_wdata
);

    import sasanqua_pkg::*;

    mem_req_t      sel_req;
    logic          sel_valid;
    logic          sel_ready;
    logic          sel_is_data;
    logic          wd_start;
    logic          wd_stop;
    logic          wd_expired;
    logic          event_valid;
    access_event_t event_info;

    access_arbiter arbiter (
        .clk         (clk),
        .rst         (rst),
        .inst_req    (inst_req),
        .inst_valid  (inst_valid),
        .inst_ready  (inst_ready),
        .data_req    (data_req),
        .data_valid  (data_valid),
        .data_ready  (data_ready),
        .sel_req     (sel_req),
        .sel_valid   (sel_valid),
        .sel_ready   (sel_ready),
        .sel_is_data (sel_is_data)
    );

    axi_access_fsm fsm (
        .clk            (clk),
        .rst            (rst),
        .sel_req        (sel_req),
        .sel_valid      (sel_valid),
        .sel_ready      (sel_ready),
        .sel_is_data    (sel_is_data),
        .ar             (ar),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .aw             (aw),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .w              (w),
        .w_valid        (w_valid),
        .w_ready        (w_ready),
        .r              (r),
        .r_valid        (r_valid),
        .r_ready        (r_ready),
        .b              (b),
        .b_valid        (b_valid),
        .b_ready        (b_ready),
        .wd_start       (wd_start),
        .wd_stop        (wd_stop),
        .wd_expired     (wd_expired),
        .inst_rsp       (inst_rsp),
        .inst_rsp_valid (inst_rsp_valid),
        .data_rsp       (data_rsp),
        .data_rsp_valid (data_rsp_valid),
        .event_valid    (event_valid),
        .event_info     (event_info)
    );

    bus_watchdog #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) watchdog (
        .clk        (clk),
        .rst        (rst),
        .wd_start   (wd_start),
        .wd_stop    (wd_stop),
        .wd_expired (wd_expired)
    );

    csr_bank csrs (
        .clk         (clk),
        .rst         (rst),
        .event_valid (event_valid),
        .event_info  (event_info),
        .csr_rden    (csr_rden),
        .csr_raddr   (csr_raddr),
        .csr_rvalid  (csr_rvalid),
        .csr_rdata   (csr_rdata),
        .csr_wren    (csr_wren),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata)
    );

endmodule

`default_nettype wire

// File: bench/axi_slave_model.sv
`timescale 1ns/100ps
`default_nettype none

module axi_slave_model #(
    parameter logic [31:0] SEED = 32'd1
) (
    input  wire                   clk,
    input  wire                   rst,
    input  sasanqua_pkg::axi_ar_t ar,
    input  wire                   ar_valid,
    output logic                  ar_ready,
    input  sasanqua_pkg::axi_aw_t aw,
    input  wire                   aw_valid,
    output logic                  aw_ready,
    input  sasanqua_pkg::axi_w_t  w,
    input  wire                   w_valid,
    output logic                  w_ready,
    output sasanqua_pkg::axi_r_t  r,
    output logic                  r_valid,
    input  wire                   r_ready,
    output sasanqua_pkg::axi_b_t  b,
    output logic                  b_valid,
    input  wire                   b_ready
);

    import sasanqua_pkg::*;

    // Word-addressed store filled only by writes
    logic [31:0] mem [logic [29:0]];

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'ha5a5_0000;
    endfunction

    task automatic random_delay();
        repeat ($urandom_range(3, 0)) @(posedge clk);
    endtask

    task automatic serve_read();
        logic [31:0] addr;
        addr = ar.addr;
        if (addr[31]) begin
            // Silent window where the master gives up on its own
            while (ar_valid) @(posedge clk);
        end else begin
            random_delay();
            ar_ready <= 1'b1;
            @(posedge clk);
            ar_ready <= 1'b0;
            random_delay();
            r <= '{data: addr[30] ? 32'd0 : read_word(addr),
                   resp: addr[30] ? RESP_SLVERR : RESP_OKAY};
            r_valid <= 1'b1;
            do @(posedge clk); while (!r_ready);
            r_valid <= 1'b0;
        end
    endtask

    task automatic serve_write();
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] word;
        addr = aw.addr;
        data = w.data;
        strb = w.strb;
        if (addr[31]) begin
            while (aw_valid || w_valid) @(posedge clk);
        end else begin
            random_delay();
            aw_ready <= 1'b1;
            w_ready  <= 1'b1;
            @(posedge clk);
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            if (!addr[30]) begin
                word = read_word(addr);
                for (int i = 0; i < 4; i++) begin
                    if (strb[i]) word[8*i +: 8] = data[8*i +: 8];
                end
                mem[addr[31:2]] = word;
            end
            random_delay();
            b <= '{resp: addr[30] ? RESP_SLVERR : RESP_OKAY};
            b_valid <= 1'b1;
            do @(posedge clk); while (!b_ready);
            b_valid <= 1'b0;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        r_valid  = 1'b0;
        b_valid  = 1'b0;
        r        = '0;
        b        = '0;
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (ar_valid) serve_read();
                else if (aw_valid && w_valid) serve_write();
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/sasanqua_assert.sv
`timescale 1ns/100ps
`default_nettype none

module sasanqua_assert (
    input wire                   clk,
    input wire                   rst,
    input sasanqua_pkg::axi_ar_t ar,
    input wire                   ar_valid,
    input wire                   ar_ready,
    input sasanqua_pkg::axi_aw_t aw,
    input wire                   aw_valid,
    input wire                   aw_ready,
    input sasanqua_pkg::axi_w_t  w,
    input wire                   w_valid,
    input wire                   w_ready,
    input wire                   r_ready,
    input wire                   b_ready,
    input wire                   inst_valid,
    input wire                   inst_ready,
    input wire                   data_valid,
    input wire                   data_ready,
    input wire                   inst_rsp_valid,
    input wire                   data_rsp_valid,
    input wire                   sel_ready,
    input wire                   wd_expired
);

    // Port of the last accepted request
    logic data_owner;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_owner <= 1'b0;
        end else if (data_valid && data_ready) begin
            data_owner <= 1'b1;
        end else if (inst_valid && inst_ready) begin
            data_owner <= 1'b0;
        end
    end

    // Watchdog expiry is the one allowed way to drop a pending valid
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready && !wd_expired |=> ar_valid && $stable(ar))
        else $error("ar_valid dropped or ar payload changed before ar_ready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready && !wd_expired |=> aw_valid && $stable(aw))
        else $error("aw_valid dropped or aw payload changed before aw_ready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready && !wd_expired |=> w_valid && $stable(w))
        else $error("w_valid dropped or w payload changed before w_ready");

    rsp_excl: assert property (@(posedge clk) disable iff (rst)
        (inst_rsp_valid || data_rsp_valid) |->
            !(inst_rsp_valid && data_rsp_valid) && (data_rsp_valid == data_owner))
        else $error("response valid on both ports or on the port that was not accepted");

    busy_not_ready: assert property (@(posedge clk) disable iff (rst)
        (ar_valid || aw_valid || w_valid || r_ready || b_ready ||
         inst_rsp_valid || data_rsp_valid) |-> !sel_ready)
        else $error("sel_ready high while a transaction is in progress");

endmodule

bind sasanqua sasanqua_assert assertions (
    .clk            (clk),
    .rst            (rst),
    .ar             (ar),
    .ar_valid       (ar_valid),
    .ar_ready       (ar_ready),
    .aw             (aw),
    .aw_valid       (aw_valid),
    .aw_ready       (aw_ready),
    .w              (w),
    .w_valid        (w_valid),
    .w_ready        (w_ready),
    .r_ready        (r_ready),
    .b_ready        (b_ready),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .data_valid     (data_valid),
    .data_ready     (data_ready),
    .inst_rsp_valid (inst_rsp_valid),
    .data_rsp_valid (data_rsp_valid),
    .sel_ready      (sel_ready),
    .wd_expired     (wd_expired)
);

`default_nettype wire

// File: bench/tb_sasanqua.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sasanqua;

    import sasanqua_pkg::*;

    localparam int          TIMEOUT_CYCLES = 16;
    localparam int          NUM_ROWS       = 10;
    localparam logic [31:0] SEED           = 32'h2fc2_c737;
    // Table rows plus the paired access and the CSR-reset access
    localparam int CYCLE_LIMIT    = (NUM_ROWS + 3) * (TIMEOUT_CYCLES + 12) + 50;

    typedef struct packed {
        logic         is_data;
        access_kind_t kind;
        logic [31:0]  addr;
        logic [31:0]  data;
        logic [3:0]   strb;
        logic         exp_err;
    } row_t;

    logic        clk;
    logic        rst;
    mem_req_t    inst_req;
    logic        inst_valid;
    logic        inst_ready;
    mem_rsp_t    inst_rsp;
    logic        inst_rsp_valid;
    mem_req_t    data_req;
    logic        data_valid;
    logic        data_ready;
    mem_rsp_t    data_rsp;
    logic        data_rsp_valid;
    axi_ar_t     ar;
    logic        ar_valid;
    logic        ar_ready;
    axi_aw_t     aw;
    logic        aw_valid;
    logic        aw_ready;
    axi_w_t      w;
    logic        w_valid;
    logic        w_ready;
    axi_r_t      r;
    logic        r_valid;
    logic        r_ready;
    axi_b_t      b;
    logic        b_valid;
    logic        b_ready;
    logic        csr_rden;
    csr_addr_t   csr_raddr;
    logic        csr_rvalid;
    logic [31:0] csr_rdata;
    logic        csr_wren;
    csr_addr_t   csr_waddr;
    logic [31:0] csr_wdata;

    row_t        rows [NUM_ROWS];
    logic [31:0] shadow [logic [29:0]];
    int          cycle_count;
    int          reads;
    int          writes;
    int          errors;
    logic [31:0] last_err_addr;

    sasanqua #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) DUT (.*);

    axi_slave_model #(.SEED(SEED)) slave (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run exceeded %0d cycles without finishing", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail at %0t: %s expected %h got %h", $time, sig, exp, act);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // Error windows read zero and unwritten words derive from the address
    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        if (addr[31] || addr[30]) return 32'd0;
        if (shadow.exists(addr[31:2])) return shadow[addr[31:2]];
        return {addr[31:2], 2'b00} ^ 32'ha5a5_0000;
    endfunction

    function automatic void shadow_write(input logic [31:0] addr, input logic [31:0] data,
                                         input logic [3:0] strb);
        logic [31:0] word;
        word = expected_read(addr);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) word[8*i +: 8] = data[8*i +: 8];
        end
        shadow[addr[31:2]] = word;
    endfunction

    function automatic void tally(input row_t rw);
        if (rw.exp_err) begin
            errors++;
            last_err_addr = rw.addr;
        end else if (rw.kind == KIND_DATA_WRITE) begin
            writes++;
        end else begin
            reads++;
        end
    endfunction

    task automatic run_row(input row_t rw);
        int          waits;
        logic [31:0] exp_data;
        mem_rsp_t    rsp;
        exp_data = expected_read(rw.addr);
        if (rw.is_data) begin
            data_req   <= '{kind: rw.kind, addr: rw.addr, wdata: rw.data, wstrb: rw.strb};
            data_valid <= 1'b1;
        end else begin
            inst_req   <= '{kind: rw.kind, addr: rw.addr, wdata: rw.data, wstrb: rw.strb};
            inst_valid <= 1'b1;
        end
        do @(posedge clk); while (!(rw.is_data ? data_ready : inst_ready));
        data_valid <= 1'b0;
        inst_valid <= 1'b0;
        waits = 0;
        do begin
            @(posedge clk);
            waits++;
            assert (!(rw.is_data ? inst_rsp_valid : data_rsp_valid))
                else report_error("response appeared on the wrong port");
        end while (!(rw.is_data ? data_rsp_valid : inst_rsp_valid));
        rsp = rw.is_data ? data_rsp : inst_rsp;
        assert (waits >= 3) else report_error("response came sooner than 3 cycles");
        assert (rsp.err == rw.exp_err)
            else report_mismatch(rw.is_data ? "data_rsp.err" : "inst_rsp.err",
                                 32'(rw.exp_err), 32'(rsp.err));
        if (rw.kind != KIND_DATA_WRITE) begin
            assert (rsp.rdata == exp_data)
                else report_mismatch(rw.is_data ? "data_rsp.rdata" : "inst_rsp.rdata",
                                     exp_data, rsp.rdata);
        end
        if (rw.addr[31]) begin
            assert (waits <= TIMEOUT_CYCLES + 2)
                else report_error("silent access outlived the watchdog bound");
        end
        if (rw.kind == KIND_DATA_WRITE && !rw.exp_err) shadow_write(rw.addr, rw.data, rw.strb);
        tally(rw);
    endtask

    // Both ports raised together and the data request must finish first
    task automatic run_pair(input logic [31:0] daddr, input logic [31:0] iaddr);
        logic data_seen;
        logic inst_seen;
        data_seen = 1'b0;
        inst_seen = 1'b0;
        data_req   <= '{kind: KIND_DATA_READ, addr: daddr, wdata: 32'd0, wstrb: 4'd0};
        inst_req   <= '{kind: KIND_INST_READ, addr: iaddr, wdata: 32'd0, wstrb: 4'd0};
        data_valid <= 1'b1;
        inst_valid <= 1'b1;
        while (!(data_seen && inst_seen)) begin
            @(posedge clk);
            if (data_valid && data_ready) data_valid <= 1'b0;
            if (inst_valid && inst_ready) inst_valid <= 1'b0;
            if (data_rsp_valid) begin
                assert (data_rsp.rdata == expected_read(daddr))
                    else report_mismatch("data_rsp.rdata", expected_read(daddr), data_rsp.rdata);
                data_seen = 1'b1;
            end
            if (inst_rsp_valid) begin
                assert (data_seen) else report_error("fetch finished before data request");
                assert (inst_rsp.rdata == expected_read(iaddr))
                    else report_mismatch("inst_rsp.rdata", expected_read(iaddr), inst_rsp.rdata);
                inst_seen = 1'b1;
            end
        end
        reads += 2;
    endtask

    task automatic csr_read_check(input csr_addr_t addr, input logic [31:0] exp,
                                  input string name);
        csr_rden  <= 1'b1;
        csr_raddr <= addr;
        @(posedge clk);
        csr_rden <= 1'b0;
        assert (!csr_rvalid) else report_error("csr_rvalid came in the csr_rden cycle");
        @(posedge clk);
        assert (csr_rvalid) else report_error("csr_rvalid missing one cycle after csr_rden");
        assert (csr_rdata == exp) else report_mismatch(name, exp, csr_rdata);
    endtask

    task automatic csr_write(input csr_addr_t addr, input logic [31:0] data);
        csr_wren  <= 1'b1;
        csr_waddr <= addr;
        csr_wdata <= data;
        @(posedge clk);
        csr_wren <= 1'b0;
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        inst_req      = '0;
        inst_valid    = 1'b0;
        data_req      = '0;
        data_valid    = 1'b0;
        csr_rden      = 1'b0;
        csr_raddr     = '0;
        csr_wren      = 1'b0;
        csr_waddr     = '0;
        csr_wdata     = '0;
        cycle_count   = 0;
        reads         = 0;
        writes        = 0;
        errors        = 0;
        last_err_addr = 32'd0;

        // is_data, kind, addr, data, strobes, expected error
        rows = '{
            '{1'b1, KIND_DATA_WRITE, 32'h0000_0100, 32'h1122_3344, 4'b1111, 1'b0},
            '{1'b1, KIND_DATA_WRITE, 32'h0000_0100, 32'haabb_ccdd, 4'b0101, 1'b0},
            '{1'b1, KIND_DATA_READ,  32'h0000_0100, 32'h0,         4'b0000, 1'b0},
            '{1'b1, KIND_DATA_WRITE, 32'h0000_0104, 32'h5566_7788, 4'b1100, 1'b0},
            '{1'b1, KIND_DATA_READ,  32'h0000_0104, 32'h0,         4'b0000, 1'b0},
            '{1'b0, KIND_INST_READ,  32'h0000_0200, 32'h0,         4'b0000, 1'b0},
            '{1'b0, KIND_INST_READ,  32'h0000_0204, 32'h0,         4'b0000, 1'b0},
            '{1'b1, KIND_DATA_READ,  32'h4000_0010, 32'h0,         4'b0000, 1'b1},
            '{1'b1, KIND_DATA_WRITE, 32'h4000_0020, 32'h1234_5678, 4'b1111, 1'b1},
            '{1'b0, KIND_INST_READ,  32'h8000_0030, 32'h0,         4'b0000, 1'b1}
        };

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        foreach (rows[i]) run_row(rows[i]);
        run_pair(32'h0000_0100, 32'h0000_0208);

        csr_read_check(CSR_READ_COUNT, reads, "csr_rdata(read count)");
        csr_read_check(CSR_WRITE_COUNT, writes, "csr_rdata(write count)");
        csr_read_check(CSR_ERROR_COUNT, errors, "csr_rdata(error count)");
        csr_read_check(CSR_ERROR_ADDR, last_err_addr, "csr_rdata(error addr)");
        csr_read_check(12'h0ff, 32'd0, "csr_rdata(unmapped)");

        csr_write(CSR_ERROR_COUNT, 32'd0);
        run_row('{1'b1, KIND_DATA_READ, 32'h4000_0040, 32'h0, 4'b0000, 1'b1});
        csr_read_check(CSR_ERROR_COUNT, 32'd1, "csr_rdata(error count after clear)");
        csr_read_check(CSR_ERROR_ADDR, 32'h4000_0040, "csr_rdata(error addr after clear)");

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/sasanqua_pkg.sv
hdl/access_arbiter.sv
hdl/axi_access_fsm.sv
hdl/bus_watchdog.sv
hdl/csr_bank.sv
hdl/sasanqua.sv
bench/axi_slave_model.sv
bench/sasanqua_assert.sv
bench/tb_sasanqua.sv

// File: Bender.yml
package:
  name: sasanqua

sources:
  - files:
      - hdl/sasanqua_pkg.sv
      - hdl/access_arbiter.sv
      - hdl/axi_access_fsm.sv
      - hdl/bus_watchdog.sv
      - hdl/csr_bank.sv
      - hdl/sasanqua.sv
  - target: test
    files:
      - bench/axi_slave_model.sv
      - bench/sasanqua_assert.sv
      - bench/tb_sasanqua.sv
